//--- source/robPkg.sv
package robPkg;

    // buffer geometry
    localparam int robSize = 16;
    localparam int robIdxWidth = 4;
    localparam int dispatchWidth = 2;
    localparam int commitWidth = 2;
    localparam int wbPorts = 2;

    // payload field widths
    localparam int excWidth = 4;
    localparam int pregWidth = 6;
    localparam int archRegWidth = 5;

    typedef logic [robIdxWidth-1:0] slotIdxT;
    typedef logic [robIdxWidth:0] countT;
    typedef logic [1:0] laneCountT;
    typedef logic [excWidth-1:0] excCodeT;
    typedef logic [pregWidth-1:0] pregT;
    typedef logic [archRegWidth-1:0] archRegT;

    // all ones marks a clean completion
    localparam excCodeT noException = '1;

    // dir flips each time the slot number wraps past the last entry
    typedef struct packed {
        logic dir;
        slotIdxT slot;
    } robIdxT;

    typedef struct packed {
        logic writesReg;
        logic isStore;
        archRegT archReg;
        pregT physReg;
        pregT oldPhysReg;
    } robPayloadT;

    typedef struct packed {
        logic valid;
        robPayloadT payload;
    } dispatchReqT;

    typedef struct packed {
        logic valid;
        robIdxT robIdx;
        excCodeT excCode;
    } wbReqT;

    typedef struct packed {
        logic valid;
        robPayloadT payload;
    } commitLaneT;

    typedef struct packed {
        laneCountT num;
        laneCountT regWriteNum;
        laneCountT storeNum;
    } commitInfoT;

    typedef struct packed {
        logic valid;
        robIdxT robIdx;
        excCodeT excCode;
    } excReportT;

endpackage

//--- source/robEntryRam.sv
module robEntryRam (
    input logic clk,
    input logic rst,
    input robPkg::dispatchReqT dispatch [robPkg::dispatchWidth],
    input logic dispatchFire,
    input robPkg::robIdxT tail,
    input robPkg::robIdxT head,
    output robPkg::robPayloadT headPayloads [robPkg::commitWidth]
);
    import robPkg::*;

    robPayloadT entries [robSize];

    // one write port per dispatch lane, consecutive slots from the tail
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entries <= '{default: '0};
        end else begin
            for (int i = 0; i < dispatchWidth; i++) begin
                if (dispatchFire && dispatch[i].valid) begin
                    entries[slotIdxT'(tail.slot + i)] <= dispatch[i].payload;
                end
            end
        end
    end

    // read ports follow the head, slot wraps on its own
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            headPayloads[i] = entries[slotIdxT'(head.slot + i)];
        end
    end

endmodule

//--- source/robStatusTable.sv
module robStatusTable (
    input logic clk,
    input logic rst,
    input robPkg::wbReqT wb [robPkg::wbPorts],
    input robPkg::dispatchReqT dispatch [robPkg::dispatchWidth],
    input logic dispatchFire,
    input robPkg::robIdxT tail,
    input robPkg::robIdxT head,
    output logic [robPkg::commitWidth-1:0] doneBits,
    output robPkg::excCodeT excCodes [robPkg::commitWidth]
);
    import robPkg::*;

    logic [robSize-1:0] done;
    excCodeT codeTable [robSize];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            // new entries start unfinished
            for (int i = 0; i < dispatchWidth; i++) begin
                if (dispatchFire && dispatch[i].valid) begin
                    done[slotIdxT'(tail.slot + i)] <= 1'b0;
                end
            end
            // later assignment, so writeback takes priority
            for (int j = 0; j < wbPorts; j++) begin
                if (wb[j].valid) begin
                    done[wb[j].robIdx.slot] <= 1'b1;
                end
            end
        end
    end

    // code is only looked at once the done bit is set
    always_ff @(posedge clk) begin
        for (int j = 0; j < wbPorts; j++) begin
            if (wb[j].valid) begin
                codeTable[wb[j].robIdx.slot] <= wb[j].excCode;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            doneBits[i] = done[slotIdxT'(head.slot + i)];
            excCodes[i] = codeTable[slotIdxT'(head.slot + i)];
        end
    end

endmodule

//--- source/robQueueCtrl.sv
module robQueueCtrl (
    input logic clk,
    input logic rst,
    input robPkg::dispatchReqT dispatch [robPkg::dispatchWidth],
    input robPkg::laneCountT retireNum,
    input logic flush,
    output robPkg::robIdxT head,
    output robPkg::robIdxT tail,
    output robPkg::countT validCount,
    output logic dispatchFire,
    output logic full
);
    import robPkg::*;

    countT freeCount;
    laneCountT reqNum;
    laneCountT addNum;
    robIdxT tailNext;

    // valid lanes are packed from lane 0, so a plain count is enough
    always_comb begin
        reqNum = '0;
        for (int i = 0; i < dispatchWidth; i++) begin
            if (dispatch[i].valid) begin
                reqNum = reqNum + 1'b1;
            end
        end
    end

    // hold off dispatch while an exception drains the buffer
    assign full = flush || (freeCount < countT'(reqNum));
    assign dispatchFire = (reqNum != '0) && !full;
    assign addNum = dispatchFire ? reqNum : '0;

    // 5-bit add carries into dir when the slot wraps
    assign tailNext = robIdxT'(tail + addNum);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            validCount <= '0;
            freeCount <= countT'(robSize);
        end else begin
            tail <= tailNext;
            if (flush) begin
                // drop everything left, head takes the tail's wrap bit too
                head <= tailNext;
                validCount <= '0;
                freeCount <= countT'(robSize);
            end else begin
                head <= robIdxT'(head + retireNum);
                validCount <= validCount + countT'(addNum) - countT'(retireNum);
                freeCount <= freeCount - countT'(addNum) + countT'(retireNum);
            end
        end
    end

endmodule

//--- source/robCommitLogic.sv
module robCommitLogic (
    input logic clk,
    input logic rst,
    input robPkg::robIdxT head,
    input robPkg::countT validCount,
    input logic [robPkg::commitWidth-1:0] doneBits,
    input robPkg::excCodeT excCodes [robPkg::commitWidth],
    input robPkg::robPayloadT headPayloads [robPkg::commitWidth],
    output robPkg::laneCountT retireNum,
    output logic flush,
    output robPkg::commitLaneT commitLanes [robPkg::commitWidth],
    output robPkg::commitInfoT commitInfo,
    output robPkg::excReportT excReport
);
    import robPkg::*;

    logic [commitWidth-1:0] eligible;
    logic [commitWidth-1:0] excLane;
    logic [commitWidth-1:0] retire;
    laneCountT excLaneIdx;
    excCodeT excSel;
    laneCountT regWriteNum;
    laneCountT storeNum;
    slotIdxT excSlot;
    robIdxT excRobIdx;

    // prefix-AND over done bits, limited to occupied lanes
    always_comb begin
        logic doneSoFar;
        doneSoFar = 1'b1;
        for (int i = 0; i < commitWidth; i++) begin
            doneSoFar = doneSoFar & doneBits[i];
            eligible[i] = doneSoFar && (countT'(i) < validCount);
        end
    end

    // first exception lane stops the group, older lanes still retire
    always_comb begin
        logic blocked;
        blocked = 1'b0;
        excLaneIdx = '0;
        excSel = noException;
        for (int i = 0; i < commitWidth; i++) begin
            excLane[i] = eligible[i] && (excCodes[i] != noException);
            if (excLane[i] && !blocked) begin
                excLaneIdx = laneCountT'(i);
                excSel = excCodes[i];
            end
            blocked = blocked | excLane[i];
            retire[i] = eligible[i] && !blocked;
        end
    end

    assign flush = |excLane;

    always_comb begin
        retireNum = '0;
        regWriteNum = '0;
        storeNum = '0;
        for (int i = 0; i < commitWidth; i++) begin
            if (retire[i]) begin
                retireNum = retireNum + 1'b1;
                regWriteNum = regWriteNum + laneCountT'(headPayloads[i].writesReg);
                storeNum = storeNum + laneCountT'(headPayloads[i].isStore);
            end
        end
    end

    // wrapped past slot 0 means the exception entry is one lap ahead
    assign excSlot = head.slot + slotIdxT'(excLaneIdx);
    assign excRobIdx = {head.dir ^ (excSlot < head.slot), excSlot};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitLanes <= '{default: '0};
            commitInfo <= '0;
            excReport <= '0;
        end else begin
            for (int i = 0; i < commitWidth; i++) begin
                commitLanes[i].valid <= retire[i];
                commitLanes[i].payload <= retire[i] ? headPayloads[i] : '0;
            end
            commitInfo.num <= retireNum;
            commitInfo.regWriteNum <= regWriteNum;
            commitInfo.storeNum <= storeNum;
            excReport.valid <= flush;
            excReport.robIdx <= flush ? excRobIdx : '0;
            excReport.excCode <= flush ? excSel : '0;
        end
    end

endmodule

//--- source/robTop.sv
module robTop (
    input logic clk,
    input logic rst,
    input robPkg::dispatchReqT dispatch [robPkg::dispatchWidth],
    input robPkg::wbReqT wb [robPkg::wbPorts],
    output robPkg::robIdxT allocIdx,
    output logic full,
    output robPkg::commitLaneT commitLanes [robPkg::commitWidth],
    output robPkg::commitInfoT commitInfo,
    output robPkg::excReportT excReport
);
    import robPkg::*;

    robIdxT head;
    robIdxT tail;
    countT validCount;
    logic dispatchFire;
    laneCountT retireNum;
    logic flush;

    // head group as seen by the commit logic
    logic [commitWidth-1:0] doneBits;
    excCodeT excCodes [commitWidth];
    robPayloadT headPayloads [commitWidth];

    // lane 0 always lands on the current tail
    assign allocIdx = tail;

    robQueueCtrl queueCtrl (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .retireNum(retireNum),
        .flush(flush),
        .head(head),
        .tail(tail),
        .validCount(validCount),
        .dispatchFire(dispatchFire),
        .full(full)
    );

    robStatusTable statusTable (
        .clk(clk),
        .rst(rst),
        .wb(wb),
        .dispatch(dispatch),
        .dispatchFire(dispatchFire),
        .tail(tail),
        .head(head),
        .doneBits(doneBits),
        .excCodes(excCodes)
    );

    robEntryRam entryRam (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .dispatchFire(dispatchFire),
        .tail(tail),
        .head(head),
        .headPayloads(headPayloads)
    );

    robCommitLogic commitLogic (
        .clk(clk),
        .rst(rst),
        .head(head),
        .validCount(validCount),
        .doneBits(doneBits),
        .excCodes(excCodes),
        .headPayloads(headPayloads),
        .retireNum(retireNum),
        .flush(flush),
        .commitLanes(commitLanes),
        .commitInfo(commitInfo),
        .excReport(excReport)
    );

endmodule

//--- tests/robTb.sv
module robTb;
    import robPkg::*;

    localparam int clkPeriod = 40;
    localparam int settleDelay = 5;
    localparam logic [31:0] lfsrSeed = 32'hf2a0;

    typedef logic [robIdxWidth:0] rawIdxT;

    typedef struct packed {
        robIdxT idx;
        robPayloadT payload;
        logic done;
        excCodeT code;
    } modelEntryT;

    typedef struct packed {
        commitLaneT [commitWidth-1:0] lanes;
        commitInfoT info;
        excReportT exc;
    } expectT;

    logic clk;
    logic rst;
    dispatchReqT dispatch [dispatchWidth];
    wbReqT wb [wbPorts];
    robIdxT allocIdx;
    logic full;
    commitLaneT commitLanes [commitWidth];
    commitInfoT commitInfo;
    excReportT excReport;

    // model of the buffer contents, oldest first
    modelEntryT model [$];
    rawIdxT nextIdx;
    expectT expected;
    logic expectArmed;
    logic [31:0] lfsrState;

    // traffic shape for the current test
    int dispMode;
    logic wbOn;
    logic excOn;

    logic lastFull;
    logic lastAccepted;
    logic excTaken;
    int twoLaneCommits;

    int errors;
    int testsRun;
    int testsFailed;
    int cyclesCompared;

    robTop DUT (
        .clk(clk),
        .rst(rst),
        .dispatch(dispatch),
        .wb(wb),
        .allocIdx(allocIdx),
        .full(full),
        .commitLanes(commitLanes),
        .commitInfo(commitInfo),
        .excReport(excReport)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(clkPeriod * 5000);
        abortRun("simulation watchdog expired");
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // in-order retirement of the head group, stops at the first unfinished or faulting entry
    function automatic expectT expectCommit(
        input int count,
        input logic [commitWidth-1:0] doneF,
        input excCodeT [commitWidth-1:0] codes,
        input robPayloadT [commitWidth-1:0] pl,
        input robIdxT [commitWidth-1:0] idx
    );
        expectT res;
        logic stopped;
        res = '0;
        stopped = 1'b0;
        for (int i = 0; i < commitWidth; i++) begin
            if (!stopped) begin
                if (i >= count || !doneF[i]) begin
                    stopped = 1'b1;
                end else if (codes[i] != noException) begin
                    res.exc.valid = 1'b1;
                    res.exc.robIdx = idx[i];
                    res.exc.excCode = codes[i];
                    stopped = 1'b1;
                end else begin
                    res.lanes[i].valid = 1'b1;
                    res.lanes[i].payload = pl[i];
                    res.info.num = res.info.num + 2'd1;
                    if (pl[i].writesReg) begin
                        res.info.regWriteNum = res.info.regWriteNum + 2'd1;
                    end
                    if (pl[i].isStore) begin
                        res.info.storeNum = res.info.storeNum + 2'd1;
                    end
                end
            end
        end
        return res;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expV,
                                  input logic [31:0] actV);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expV, actV);
        errors++;
    endtask

    task automatic reportFailure(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        errors++;
    endtask

    task automatic abortRun(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        $display("Regression failed");
        $finish;
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        testsRun++;
        if (errors == errsBefore) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - errsBefore);
        end
    endtask

    // registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (expectArmed) begin
            cyclesCompared++;
            for (int i = 0; i < commitWidth; i++) begin
                if (commitLanes[i] !== expected.lanes[i]) begin
                    reportMismatch($sformatf("commitLanes[%0d]", i), 32'(expected.lanes[i]),
                                   32'(commitLanes[i]));
                end
            end
            if (commitInfo !== expected.info) begin
                reportMismatch("commitInfo", 32'(expected.info), 32'(commitInfo));
            end
            if (excReport !== expected.exc) begin
                reportMismatch("excReport", 32'(expected.exc), 32'(excReport));
            end
        end
    end

    task automatic runCycle();
        int reqLanes;
        int cand [$];
        int wbPos [wbPorts];
        int pick;
        logic expFull;
        logic [31:0] bits;
        logic [commitWidth-1:0] doneF;
        excCodeT [commitWidth-1:0] codes;
        robPayloadT [commitWidth-1:0] pl;
        robIdxT [commitWidth-1:0] idx;
        expectT exp;
        modelEntryT entry;

        @(negedge clk);
        case (dispMode)
            1: reqLanes = int'(takeBits(2)) % 3;
            2: reqLanes = dispatchWidth;
            default: reqLanes = 0;
        endcase
        for (int i = 0; i < dispatchWidth; i++) begin
            dispatch[i] = '0;
            if (i < reqLanes) begin
                bits = takeBits($bits(robPayloadT));
                dispatch[i].valid = 1'b1;
                dispatch[i].payload = bits[$bits(robPayloadT)-1:0];
            end
        end

        // writeback only to allocated, unfinished entries, never two ports on one entry
        for (int p = 0; p < model.size(); p++) begin
            if (!model[p].done) begin
                cand.push_back(p);
            end
        end
        for (int j = 0; j < wbPorts; j++) begin
            wb[j] = '0;
            wbPos[j] = -1;
            if (wbOn && cand.size() > 0 && takeBits(2) != 0) begin
                pick = int'(takeBits(5)) % cand.size();
                wbPos[j] = cand[pick];
                cand.delete(pick);
                wb[j].valid = 1'b1;
                wb[j].robIdx = model[wbPos[j]].idx;
                wb[j].excCode = noException;
                if (excOn && takeBits(3) == 0) begin
                    wb[j].excCode = excCodeT'(int'(takeBits(4)) % 15);
                end
            end
        end

        #settleDelay;
        for (int i = 0; i < commitWidth; i++) begin
            if (i < model.size()) begin
                doneF[i] = model[i].done;
                codes[i] = model[i].code;
                pl[i] = model[i].payload;
                idx[i] = model[i].idx;
            end else begin
                doneF[i] = 1'b0;
                codes[i] = noException;
                pl[i] = '0;
                idx[i] = '0;
            end
        end
        exp = expectCommit(model.size(), doneF, codes, pl, idx);
        expFull = exp.exc.valid || ((robSize - model.size()) < reqLanes);
        if (full !== expFull) begin
            reportMismatch("full", 32'(expFull), 32'(full));
        end
        if (allocIdx !== nextIdx) begin
            reportMismatch("allocIdx", 32'(nextIdx), 32'(allocIdx));
        end
        expected = exp;
        expectArmed = 1'b1;
        lastFull = full;
        if (exp.info.num == 2'd2) begin
            twoLaneCommits++;
        end
        if (exp.exc.valid) begin
            excTaken = 1'b1;
        end

        // writebacks land before the queue shifts
        for (int j = 0; j < wbPorts; j++) begin
            if (wbPos[j] >= 0) begin
                entry = model[wbPos[j]];
                entry.done = 1'b1;
                entry.code = wb[j].excCode;
                model[wbPos[j]] = entry;
            end
        end
        for (int n = 0; n < int'(exp.info.num); n++) begin
            void'(model.pop_front());
        end
        if (exp.exc.valid) begin
            model.delete();
        end

        lastAccepted = 1'b0;
        if (!full && reqLanes > 0) begin
            for (int i = 0; i < reqLanes; i++) begin
                entry.idx = nextIdx + rawIdxT'(i);
                entry.payload = dispatch[i].payload;
                entry.done = 1'b0;
                entry.code = noException;
                model.push_back(entry);
            end
            nextIdx = nextIdx + rawIdxT'(reqLanes);
            lastAccepted = 1'b1;
        end
    endtask

    task automatic drainBuffer(input int limit);
        int guard;
        dispMode = 0;
        wbOn = 1'b1;
        excOn = 1'b0;
        guard = 0;
        while (model.size() > 0 && guard < limit) begin
            runCycle();
            guard++;
        end
        if (model.size() > 0) begin
            abortRun("timeout while draining the buffer");
        end
    endtask

    initial begin
        int errsBefore;
        int guard;
        robIdxT heldIdx;

        rst = 1'b1;
        for (int i = 0; i < dispatchWidth; i++) begin
            dispatch[i] = '0;
        end
        for (int j = 0; j < wbPorts; j++) begin
            wb[j] = '0;
        end
        lfsrState = lfsrSeed;
        nextIdx = '0;
        expected = '0;
        expectArmed = 1'b0;
        dispMode = 0;
        wbOn = 1'b0;
        excOn = 1'b0;
        lastFull = 1'b0;
        lastAccepted = 1'b0;
        excTaken = 1'b0;
        twoLaneCommits = 0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        cyclesCompared = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state, then dispatch until the wrap bit has flipped
        errsBefore = errors;
        #1;
        if (full !== 1'b0) begin
            reportMismatch("full", 32'd0, 32'(full));
        end
        if (allocIdx !== nextIdx) begin
            reportMismatch("allocIdx", 32'(nextIdx), 32'(allocIdx));
        end
        for (int i = 0; i < commitWidth; i++) begin
            if (commitLanes[i] !== '0) begin
                reportMismatch($sformatf("commitLanes[%0d]", i), 32'd0, 32'(commitLanes[i]));
            end
        end
        if (commitInfo !== '0) begin
            reportMismatch("commitInfo", 32'd0, 32'(commitInfo));
        end
        if (excReport !== '0) begin
            reportMismatch("excReport", 32'd0, 32'(excReport));
        end
        dispMode = 1;
        wbOn = 1'b1;
        guard = 0;
        while (!(nextIdx[robIdxWidth] && nextIdx[robIdxWidth-1:0] >= 4) && guard < 300) begin
            runCycle();
            guard++;
        end
        if (!nextIdx[robIdxWidth]) begin
            abortRun("timeout waiting for the ROB index to wrap");
        end
        drainBuffer(200);
        finishTest("resetAndDispatch", errsBefore);

        errsBefore = errors;
        dispMode = 1;
        wbOn = 1'b1;
        repeat (200) runCycle();
        drainBuffer(300);
        finishTest("outOfOrderWriteback", errsBefore);

        errsBefore = errors;
        twoLaneCommits = 0;
        dispMode = 2;
        wbOn = 1'b1;
        repeat (150) runCycle();
        if (twoLaneCommits == 0) begin
            reportFailure("no cycle retired a full two-entry group");
        end
        drainBuffer(300);
        finishTest("commitCounts", errsBefore);

        // fill without writeback, then hold the requests while full
        errsBefore = errors;
        dispMode = 2;
        wbOn = 1'b0;
        guard = 0;
        lastFull = 1'b0;
        while (!lastFull && guard < 20) begin
            runCycle();
            guard++;
        end
        if (!lastFull) begin
            abortRun("timeout waiting for full to rise");
        end
        heldIdx = allocIdx;
        repeat (4) runCycle();
        if (allocIdx !== heldIdx) begin
            reportMismatch("allocIdx", 32'(heldIdx), 32'(allocIdx));
        end
        wbOn = 1'b1;
        guard = 0;
        lastAccepted = 1'b0;
        while (!lastAccepted && guard < 40) begin
            runCycle();
            guard++;
        end
        if (!lastAccepted) begin
            abortRun("timeout waiting for full to fall after retirement");
        end
        drainBuffer(200);
        finishTest("fullAndDrop", errsBefore);

        errsBefore = errors;
        dispMode = 2;
        wbOn = 1'b0;
        repeat (3) runCycle();
        dispMode = 1;
        wbOn = 1'b1;
        excOn = 1'b1;
        excTaken = 1'b0;
        guard = 0;
        while (!excTaken && guard < 200) begin
            runCycle();
            guard++;
        end
        if (!excTaken) begin
            abortRun("timeout waiting for an exception to be taken");
        end
        // an empty buffer takes a full two-lane group at once
        dispMode = 2;
        wbOn = 1'b0;
        runCycle();
        if (lastFull) begin
            reportFailure("buffer still holds entries after the exception");
        end
        dispMode = 1;
        wbOn = 1'b1;
        repeat (150) runCycle();
        drainBuffer(300);
        finishTest("exception", errsBefore);

        @(negedge clk);
        #1;
        expectArmed = 1'b0;
        $display("summary: %0d tests, %0d failed, %0d cycles compared, %0d errors",
                 testsRun, testsFailed, cyclesCompared, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- robTop.f
source/robPkg.sv
source/robEntryRam.sv
source/robStatusTable.sv
source/robQueueCtrl.sv
source/robCommitLogic.sv
source/robTop.sv
tests/robTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the ROB testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module robTb -f robTop.f -o robSim

./obj_dir/robSim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "result: PASS"
    exit 0
else
    echo "result: FAIL"
    exit 1
fi
